/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // --------------------
    // exception codes, MIPS ExcCode numbering
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_priv;
    } ctrl_sign_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
    } except_t;

    // --------------------
    // one issue lane between pipeline stages
    typedef struct packed {
        ctrl_sign_t  ctrl;
        except_t     except;
        logic        reg_wen;
        logic        mem_sel;     // lane owns the memory request
        logic        in_delayslot;
        logic [4:0]  reg_waddr;
        logic [31:0] inst;
        logic [31:0] alu_res;
        logic [31:0] pc;
        logic        valid;
    } lane_t;

    typedef struct packed {
        logic        valid;
        logic        reg_wen;
        logic [4:0]  reg_waddr;
        logic [31:0] wdata;
        logic [31:0] pc;
        except_t     except;
    } wb_t;

endpackage

`default_nettype wire

/* design/dmem_credit_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_credit_port
    import mem_pkg::*;
#(
    parameter int DMEM_CREDITS = 4
) (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire mem_req_t  m_mem,
    output logic           stall,
    output logic           dmem_req_valid,
    output dmem_req_t      dmem_req,
    input  wire logic      dmem_credit_ret,
    input  wire logic      dmem_rsp_valid,
    input  wire dmem_rsp_t dmem_rsp,
    output logic           load_done,
    output logic [31:0]    load_data
);

    localparam int CW = $clog2(DMEM_CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          load_pend;   // load sent, response not back yet
    logic          m_is_load;
    logic          no_credit;
    logic          issue;

    assign m_is_load = m_mem.valid && !m_mem.wen;
    assign no_credit = (credit_cnt == '0);
    assign issue     = m_mem.valid && !load_pend && !no_credit;

    // --------------------
    // request channel
    assign dmem_req_valid    = issue;
    assign dmem_req.wen      = m_mem.wen;
    assign dmem_req.pa       = m_mem.pa;
    assign dmem_req.wdata    = mem_wdata_align(m_mem.op, m_mem.wdata);
    assign dmem_req.strb     = mem_strb(m_mem.op, m_mem.addr[1:0]);
    assign dmem_req.uncached = m_mem.uncached;

    // hold M until a credit shows up, loads also until their data
    assign stall = (m_mem.valid && !load_pend && no_credit)
                   || (m_is_load && !dmem_rsp_valid);

    assign load_done = dmem_rsp_valid && load_pend;
    assign load_data = dmem_rsp.rdata;

    // --------------------
    // credits and load tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            credit_cnt <= CW'(DMEM_CREDITS);
        else
            credit_cnt <= credit_cnt - CW'(issue) + CW'(dmem_credit_ret);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            load_pend <= 1'b0;
        else if (dmem_rsp_valid)
            load_pend <= 1'b0;
        else if (issue && m_is_load)
            load_pend <= 1'b1;
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= CW'(DMEM_CREDITS));

    // memory may not hand back a credit it never received
    a_credit_ret: assert property (@(posedge clk) disable iff (!arst_n)
        (credit_cnt == CW'(DMEM_CREDITS) && dmem_credit_ret) |-> issue);

    // responses only for the one outstanding load
    a_rsp_owner: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_rsp_valid |-> load_pend);

endmodule

`default_nettype wire

/* design/ex_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem
    import cpu_pkg::*;
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     ena_master,
    input  wire logic     ena_slave,
    input  wire logic     clear_master,
    input  wire logic     clear_slave,
    input  wire lane_t    e_master,
    input  wire lane_t    e_slave,
    input  wire mem_req_t e_mem,
    output lane_t         m_master,
    output lane_t         m_slave,
    output mem_req_t      m_mem
);

    // --------------------
    // master group with the memory request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_master <= '0;
            m_mem    <= '0;
        end else begin
            if (clear_master)
                m_master <= '0;
            else if (ena_master)
                m_master <= e_master;
            // the slave half of a split pair loads its request here too
            if (ena_master || ena_slave)
                m_mem <= e_mem;
        end
    end

    // --------------------
    // slave group
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            m_slave <= '0;
        else if (clear_slave)
            m_slave <= '0;
        else if (ena_slave)
            m_slave <= e_slave;
    end

    // the request in M always belongs to a lane sitting in M
    a_mem_owner: assert property (@(posedge clk) disable iff (!arst_n)
        m_mem.valid |-> (m_master.valid && m_master.mem_sel)
                        || (m_slave.valid && m_slave.mem_sel));

endmodule

`default_nettype wire

/* design/load_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module load_formatter
    import cpu_pkg::*;
    import mem_pkg::*;
(
    input  wire lane_t       m_master,
    input  wire lane_t       m_slave,
    input  wire mem_req_t    m_mem,
    input  wire logic        stall,
    input  wire logic        load_done,
    input  wire logic [31:0] load_data,
    output wb_t              wb_master,
    output wb_t              wb_slave
);

    logic [31:0] shifted;
    logic [31:0] ld_res;

    assign shifted = load_data >> {m_mem.addr[1:0], 3'b000};   // addressed byte to lane 0

    always_comb begin
        case (m_mem.op)
            MEM_LB:  ld_res = {{24{shifted[7]}}, shifted[7:0]};
            MEM_LBU: ld_res = {24'h0, shifted[7:0]};
            MEM_LH:  ld_res = {{16{shifted[15]}}, shifted[15:0]};
            MEM_LHU: ld_res = {16'h0, shifted[15:0]};
            default: ld_res = load_data;
        endcase
    end

    function automatic wb_t make_wb(lane_t l, logic go, logic ld, logic [31:0] res);
        wb_t w;
        w.valid     = l.valid && go;
        w.reg_wen   = l.reg_wen;
        w.reg_waddr = l.reg_waddr;
        w.wdata     = (ld && l.mem_sel) ? res : l.alu_res;
        w.pc        = l.pc;
        w.except    = l.except;
        return w;
    endfunction

    assign wb_master = make_wb(m_master, !stall, load_done, ld_res);
    assign wb_slave  = make_wb(m_slave, !stall, load_done, ld_res);

endmodule

`default_nettype wire

/* design/mem_lane_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_lane_arbiter
    import cpu_pkg::*;
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire lane_t    e_master,
    input  wire lane_t    e_slave,
    input  wire mem_req_t e_master_mem,
    input  wire mem_req_t e_slave_mem,
    input  wire logic     stall,
    output logic          e_ready,
    output logic          ena_master,
    output logic          ena_slave,
    output logic          clear_master,
    output logic          clear_slave,
    output mem_req_t      sel_mem
);

    logic taken;   // first half of a split pair already in M
    logic m_exc;
    logic m_want;
    logic s_want;
    logic split;

    assign m_exc  = e_master.valid && e_master.except.valid;
    assign m_want = e_master.valid && e_master.mem_sel && !e_master.except.valid;
    assign s_want = e_slave.valid && e_slave.mem_sel && !e_slave.except.valid;
    assign split  = e_master.valid && e_master.mem_sel && e_slave.valid && e_slave.mem_sel
                    && !m_exc;

    always_comb begin
        e_ready      = 1'b0;
        ena_master   = 1'b0;
        ena_slave    = 1'b0;
        clear_master = 1'b0;
        clear_slave  = 1'b0;
        sel_mem      = '0;
        if (!stall) begin
            if (!split) begin
                e_ready     = 1'b1;
                ena_master  = 1'b1;
                ena_slave   = 1'b1;
                clear_slave = m_exc;                        // flush behind a master exception
                if (m_want)
                    sel_mem = e_master_mem;
                else if (s_want && !m_exc)
                    sel_mem = e_slave_mem;
            end else if (!taken) begin
                ena_master  = 1'b1;                         // master half, slave held back
                ena_slave   = 1'b1;
                clear_slave = 1'b1;
                sel_mem     = e_master_mem;
            end else begin
                e_ready      = 1'b1;                        // slave half completes the pair
                clear_master = 1'b1;
                ena_slave    = 1'b1;
                if (s_want)
                    sel_mem = e_slave_mem;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            taken <= 1'b0;
        else if (!stall)
            taken <= split && !taken;
    end

    // a pair that really enters M on both lanes must never carry a request
    a_no_dual_mem: assert property (@(posedge clk) disable iff (!arst_n)
        (ena_master && !clear_master && ena_slave && !clear_slave
         && e_master.valid && e_master.mem_sel && e_slave.valid && e_slave.mem_sel)
        |-> !sel_mem.valid);

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // load/store opcodes, same values as the MIPS major opcode
    typedef enum logic [5:0] {
        MEM_LB  = 6'h20,
        MEM_LH  = 6'h21,
        MEM_LW  = 6'h23,
        MEM_LBU = 6'h24,
        MEM_LHU = 6'h25,
        MEM_SB  = 6'h28,
        MEM_SH  = 6'h29,
        MEM_SW  = 6'h2b
    } mem_op_t;

    typedef struct packed {
        logic        valid;
        logic        wen;
        mem_op_t     op;
        logic [31:0] addr;        // virtual
        logic [31:0] pa;
        logic [31:0] wdata;
        logic        uncached;
    } mem_req_t;

    typedef struct packed {
        logic        wen;
        logic [31:0] pa;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        uncached;
    } dmem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } dmem_rsp_t;

    // --------------------
    // byte lanes touched by an access
    function automatic logic [3:0] mem_strb(mem_op_t op, logic [1:0] off);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: mem_strb = 4'b0001 << off;
            MEM_LH, MEM_LHU, MEM_SH: mem_strb = 4'b0011 << {off[1], 1'b0};
            default:                 mem_strb = 4'b1111;
        endcase
    endfunction

    // store data copied onto every lane, strobe picks the live one
    function automatic logic [31:0] mem_wdata_align(mem_op_t op, logic [31:0] wdata);
        case (op)
            MEM_SB:  mem_wdata_align = {4{wdata[7:0]}};
            MEM_SH:  mem_wdata_align = {2{wdata[15:0]}};
            default: mem_wdata_align = wdata;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top
    import cpu_pkg::*;
    import mem_pkg::*;
#(
    parameter int DMEM_CREDITS = 4
) (
    input  wire logic      clk,
    input  wire logic      arst_n,
    // execute side
    input  wire lane_t     e_master,
    input  wire lane_t     e_slave,
    input  wire mem_req_t  e_master_mem,
    input  wire mem_req_t  e_slave_mem,
    output logic           e_ready,
    // data memory channel
    output logic           dmem_req_valid,
    output dmem_req_t      dmem_req,
    input  wire logic      dmem_credit_ret,
    input  wire logic      dmem_rsp_valid,
    input  wire dmem_rsp_t dmem_rsp,
    // write-back
    output wb_t            wb_master,
    output wb_t            wb_slave
);

    logic        ena_master;
    logic        ena_slave;
    logic        clear_master;
    logic        clear_slave;
    logic        stall;
    logic        load_done;
    logic [31:0] load_data;
    mem_req_t    sel_mem;
    mem_req_t    m_mem;
    lane_t       m_master;
    lane_t       m_slave;

    mem_lane_arbiter arb0 (
        .clk, .arst_n, .e_master, .e_slave, .e_master_mem, .e_slave_mem,
        .stall, .e_ready, .ena_master, .ena_slave, .clear_master, .clear_slave,
        .sel_mem
    );

    ex_mem ex_mem0 (
        .clk, .arst_n, .ena_master, .ena_slave, .clear_master, .clear_slave,
        .e_master, .e_slave, .e_mem(sel_mem), .m_master, .m_slave, .m_mem
    );

    dmem_credit_port #(
        .DMEM_CREDITS(DMEM_CREDITS)
    ) port0 (
        .clk, .arst_n, .m_mem, .stall, .dmem_req_valid, .dmem_req,
        .dmem_credit_ret, .dmem_rsp_valid, .dmem_rsp, .load_done, .load_data
    );

    load_formatter fmt0 (
        .m_master, .m_slave, .m_mem, .stall, .load_done, .load_data,
        .wb_master, .wb_slave
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_stage -f sources.f -Mdir obj_dir -o tb_mem_stage &&
./obj_dir/tb_mem_stage ||
exit 1

/* sim/tb_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dmem
    import mem_pkg::*;
#(
    parameter int DMEM_CREDITS = 4
) (
    input  wire logic      clk,
    input  wire logic      arst_n,
    input  wire logic      slow_credit,
    input  wire logic      req_valid,
    input  wire dmem_req_t req,
    output logic           credit_ret,
    output logic           rsp_valid,
    output dmem_rsp_t      rsp,
    output logic           overrun
);

    localparam logic [31:0] BASE = 32'h0000_1000;

    logic [31:0] mem [64];
    int          held;       // requests received, credit not yet given back
    int          rsp_wait;
    int          n;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        for (int i = 0; i < 64; i++)
            mem[6'(i)] = fill_word(BASE + 32'(i) * 32'd4);
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_ret <= 1'b0;
            rsp_valid  <= 1'b0;
            rsp        <= '0;
            overrun    <= 1'b0;
            held        = 0;
            rsp_wait    = 0;
        end else begin
            n = held;
            rsp_valid <= (rsp_wait == 1);
            if (rsp_wait != 0)
                rsp_wait = rsp_wait - 1;
            if (req_valid) begin
                if (n == DMEM_CREDITS)
                    overrun <= 1'b1;     // sender ignored the credit limit
                n = n + 1;
                if (req.wen) begin
                    if (req.strb[0])
                        mem[req.pa[7:2]][7:0] = req.wdata[7:0];
                    if (req.strb[1])
                        mem[req.pa[7:2]][15:8] = req.wdata[15:8];
                    if (req.strb[2])
                        mem[req.pa[7:2]][23:16] = req.wdata[23:16];
                    if (req.strb[3])
                        mem[req.pa[7:2]][31:24] = req.wdata[31:24];
                end else begin
                    rsp.rdata <= mem[req.pa[7:2]];
                    rsp_wait = 1 + $urandom % 6;
                end
            end
            credit_ret <= 1'b0;
            if (n > 0 && $urandom % (slow_credit ? 8 : 2) == 0) begin
                credit_ret <= 1'b1;
                n = n - 1;
            end
            held = n;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import cpu_pkg::*;
    import mem_pkg::*;
();

    localparam int          CREDITS    = 4;
    localparam int          N_PAIRS    = 2000;
    localparam int          SLOW_FROM  = 1500;   // tail of the run with credits coming back slowly
    localparam int          MAX_CYCLES = N_PAIRS * 16;
    localparam logic [31:0] SEED       = 32'ha398;
    localparam logic [31:0] BASE       = 32'h0000_1000;

    logic        clk;
    logic        arst_n;
    lane_t       e_master;
    lane_t       e_slave;
    mem_req_t    e_master_mem;
    mem_req_t    e_slave_mem;
    logic        e_ready;
    logic        dmem_req_valid;
    dmem_req_t   dmem_req;
    logic        dmem_credit_ret;
    logic        dmem_rsp_valid;
    dmem_rsp_t   dmem_rsp;
    wb_t         wb_master;
    wb_t         wb_slave;
    logic        slow_credit;
    logic        dmem_overrun;

    logic [31:0] model_mem [64];
    wb_t         exp_q [$];
    logic [33:0] req_q [$];  // wen, pa, uncached
    mem_op_t     op_list [8];
    logic [31:0] pc_next;
    int          cycle_cnt = 0;
    int          wb_cnt = 0;

    mem_stage_top #(
        .DMEM_CREDITS(CREDITS)
    ) dut0 (
        .clk, .arst_n, .e_master, .e_slave, .e_master_mem, .e_slave_mem, .e_ready,
        .dmem_req_valid, .dmem_req, .dmem_credit_ret, .dmem_rsp_valid, .dmem_rsp,
        .wb_master, .wb_slave
    );

    tb_dmem #(
        .DMEM_CREDITS(CREDITS)
    ) mem0 (
        .clk, .arst_n, .slow_credit, .req_valid(dmem_req_valid), .req(dmem_req),
        .credit_ret(dmem_credit_ret), .rsp_valid(dmem_rsp_valid), .rsp(dmem_rsp),
        .overrun(dmem_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [95:0] exp,
                               input logic [95:0] act);
        if (exp !== act)
            stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // --------------------
    function automatic logic [31:0] model_load(input mem_req_t r);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = model_mem[r.pa[7:2]];
        b    = word[{r.addr[1:0], 3'b000} +: 8];
        h    = r.addr[1] ? word[31:16] : word[15:0];
        case (r.op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic model_store(input mem_req_t r);
        logic [31:0] word;
        word = model_mem[r.pa[7:2]];
        case (r.op)
            MEM_SB:  word[{r.addr[1:0], 3'b000} +: 8] = r.wdata[7:0];
            MEM_SH: begin
                if (r.addr[1])
                    word[31:16] = r.wdata[15:0];
                else
                    word[15:0] = r.wdata[15:0];
            end
            default: word = r.wdata;
        endcase
        model_mem[r.pa[7:2]] = word;
    endtask

    task automatic expect_lane(input lane_t l, input mem_req_t r, input logic do_mem);
        wb_t w;
        w.valid     = 1'b1;
        w.reg_wen   = l.reg_wen;
        w.reg_waddr = l.reg_waddr;
        w.wdata     = l.alu_res;
        w.pc        = l.pc;
        w.except    = l.except;
        if (do_mem && l.mem_sel) begin
            req_q.push_back({r.wen, r.pa, r.uncached});
            if (r.wen)
                model_store(r);
            else
                w.wdata = model_load(r);
        end
        exp_q.push_back(w);
    endtask

    task automatic make_lane(output lane_t l, output mem_req_t r, input logic may_trap);
        logic [5:0] idx;
        logic [1:0] off;
        l           = '0;
        r           = '0;
        l.valid     = 1'b1;
        l.reg_wen   = 1'($urandom);
        l.reg_waddr = 5'($urandom);
        l.inst      = $urandom;
        l.alu_res   = $urandom;
        l.pc        = pc_next;
        l.mem_sel   = 1'($urandom);
        pc_next     = pc_next + 32'd4;
        if (l.mem_sel) begin
            r.op = op_list[3'($urandom)];
            idx  = 6'($urandom);
            off  = 2'($urandom);
            case (r.op)
                MEM_LH, MEM_LHU, MEM_SH: off[0] = 1'b0;
                MEM_LW, MEM_SW:          off = 2'b00;
                default: ;
            endcase
            r.valid          = 1'b1;
            r.wen            = (r.op == MEM_SB) || (r.op == MEM_SH) || (r.op == MEM_SW);
            r.addr           = BASE + {24'h0, idx, off};
            r.pa             = r.addr;
            r.wdata          = $urandom;
            r.uncached       = 1'($urandom);
            l.ctrl.is_load   = !r.wen;
            l.ctrl.is_store  = r.wen;
            l.reg_wen        = !r.wen;
        end
        if (may_trap && 4'($urandom) == 4'd0) begin
            l.except.valid = 1'b1;
            l.except.code  = EXC_OV;
        end
    endtask

    // the model takes the pair in program order, the DUT keeps it until e_ready
    task automatic send_pair(input lane_t m, input lane_t s, input mem_req_t mm,
                             input mem_req_t sm);
        @(posedge clk);
        e_master     <= m;
        e_slave      <= s;
        e_master_mem <= mm;
        e_slave_mem  <= sm;
        expect_lane(m, mm, !m.except.valid);
        if (!m.except.valid)
            expect_lane(s, sm, 1'b1);    // master exception flushes the slave
        @(negedge clk);
        while (!e_ready)
            @(negedge clk);
    endtask

    task automatic take_wb(input string lane, input wb_t act);
        wb_t exp;
        if (exp_q.size() == 0) begin
            stop_with_error($sformatf("unexpected %s write-back at pc %h", lane, act.pc));
        end else begin
            exp = exp_q.pop_front();
            check_equal($sformatf("%s write-back %0d", lane, wb_cnt), 96'(exp), 96'(act));
            wb_cnt++;
        end
    endtask

    task automatic take_req(input dmem_req_t act);
        logic [33:0] exp;
        if (req_q.size() == 0) begin
            stop_with_error($sformatf("unexpected memory request to %h", act.pa));
        end else begin
            exp = req_q.pop_front();
            check_equal("memory request", 96'(exp), 96'({act.wen, act.pa, act.uncached}));
        end
    endtask

    // --------------------
    always @(negedge clk) begin
        if (arst_n) begin
            if (dmem_overrun)
                stop_with_error("data memory got a request while all its credits were in use");
            if (dmem_req_valid)
                take_req(dmem_req);
            if (wb_master.valid)
                take_wb("master", wb_master);
            if (wb_slave.valid)
                take_wb("slave", wb_slave);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            stop_with_error($sformatf("timeout after %0d cycles, %0d write-backs still missing",
                                      cycle_cnt, exp_q.size()));
    end

    initial begin
        lane_t    m;
        lane_t    s;
        mem_req_t mm;
        mem_req_t sm;
        void'($urandom(SEED));
        op_list      = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW};
        pc_next      = 32'hbfc0_0000;
        arst_n       = 1'b0;
        e_master     = '0;
        e_slave      = '0;
        e_master_mem = '0;
        e_slave_mem  = '0;
        slow_credit  = 1'b0;
        for (int i = 0; i < 64; i++)
            model_mem[6'(i)] = fill_word(BASE + 32'(i) * 32'd4);
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < N_PAIRS; i++) begin
            if (i == SLOW_FROM)
                slow_credit <= 1'b1;
            make_lane(m, mm, 1'b1);
            make_lane(s, sm, 1'b0);
            send_pair(m, s, mm, sm);
        end
        @(posedge clk);
        e_master     <= '0;
        e_slave      <= '0;
        e_master_mem <= '0;
        e_slave_mem  <= '0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(posedge clk);       // last store reaches memory
        check_equal("memory requests left", 96'(0), 96'(req_q.size()));
        for (int i = 0; i < 64; i++)
            check_equal($sformatf("memory word %0d", i), 96'(model_mem[6'(i)]),
                        96'(mem0.mem[6'(i)]));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/cpu_pkg.sv
design/mem_pkg.sv
design/mem_lane_arbiter.sv
design/ex_mem.sv
design/dmem_credit_port.sv
design/load_formatter.sv
design/mem_stage_top.sv
sim/tb_dmem.sv
sim/tb_mem_stage.sv
